// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_sram_ctl
FILELIST := sram_ctl.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
FAIL_MSG := sim failed
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/cfg_reg.sv ====
// ------------------------------
// cfg0 control register
// load, set, clear or toggle update
// drives the four status outputs
// ------------------------------

`timescale 1ns/1ps

`include "sram_ctl_consts.svh"

module cfg_reg (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        cfg_we,
  input  sram_ctl_pkg::wr_op_t        cfg_op,
  input  logic [`SRAM_CTL_DW-1:0]     cfg_wdat,
  output logic [`SRAM_CTL_DW-1:0]     cfg0,
  output logic                        run_mode,
  output logic                        error,
  output logic [1:0]                  user_out
);

  // cfg0 layout
  //   31     run mode
  //   30     error
  //   29:28  user outputs
  //   2:0    read wait count
  logic [`SRAM_CTL_DW-1:0] cfg0_q;
  logic [`SRAM_CTL_DW-1:0] cfg0_nxt;

  // new value per write op
  always_comb begin
    case (cfg_op)
      sram_ctl_pkg::WR_LOAD:  cfg0_nxt = cfg_wdat;
      sram_ctl_pkg::WR_SET:   cfg0_nxt = cfg0_q | cfg_wdat;
      sram_ctl_pkg::WR_CLEAR: cfg0_nxt = cfg0_q & ~cfg_wdat;
      default:                cfg0_nxt = cfg0_q ^ cfg_wdat;
    endcase
  end

  // update lands at the end of the command cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg0_q <= `SRAM_CTL_CFG0_INIT;
    end else if (cfg_we) begin
      cfg0_q <= cfg0_nxt;
    end
  end

  assign cfg0 = cfg0_q;

  // status outputs straight from the top nibble
  assign user_out = cfg0_q[`SRAM_CTL_STATUS_LSB +: 2];
  assign error    = cfg0_q[`SRAM_CTL_STATUS_LSB + 2];
  assign run_mode = cfg0_q[`SRAM_CTL_STATUS_LSB + 3];

endmodule

// ==== source/cmd_decode.sv ====
// ------------------------------
// command decode
// splits host commands into array
// drives, cfg0 writes and read kinds
// ------------------------------

`timescale 1ns/1ps

`include "sram_ctl_consts.svh"

module cmd_decode (
  input  logic                          ctl_cmd_val,
  input  logic                          ra0_cmd_val,
  input  logic [`SRAM_CTL_DW-1:0]       cmd_adr,
  input  logic                          cmd_we,
  input  logic [3:0]                    cmd_sel,
  input  logic [`SRAM_CTL_DW-1:0]       cmd_dat,
  output logic                          cfg_we,
  output sram_ctl_pkg::wr_op_t          cfg_op,
  output logic                          rd_req,
  output sram_ctl_pkg::seq_state_t      rd_target,
  output logic                          r0_enb,
  output logic [`SRAM_CTL_AW-1:0]       r0_adr,
  output logic                          r1_enb,
  output logic [`SRAM_CTL_AW-1:0]       r1_adr,
  output logic                          w0_enb,
  output logic [`SRAM_CTL_AW-1:0]       w0_adr,
  output logic [`SRAM_CTL_DW-1:0]       w0_dat,
  output logic [`SRAM_CTL_DW-1:0]       bist_ctl,
  output logic                          cfg_wr,
  output logic [`SRAM_CTL_DW-1:0]       cfg_wdat
);

  logic [`SRAM_CTL_DW-1:0] space;
  logic                    adr_cfg0;
  logic                    adr_bist;
  logic                    adr_arrcfg;
  logic                    special;
  sram_ctl_pkg::rd_port_t  rd_type;

  // space select, only the masked bits count
  assign space      = cmd_adr & `SRAM_CTL_SPACE_MASK;
  assign adr_cfg0   = ctl_cmd_val & (space == `SRAM_CTL_CFG0_OFFSET);
  assign adr_bist   = ra0_cmd_val & (space == `SRAM_CTL_BIST_OFFSET);
  assign adr_arrcfg = ra0_cmd_val & (space == `SRAM_CTL_ARRCFG_OFFSET);
  // bist and array config never touch the array ports
  assign special    = adr_bist | adr_arrcfg;

  // cfg0 write and its op
  assign cfg_we = adr_cfg0 & cmd_we;
  assign cfg_op = sram_ctl_pkg::wr_op_t'(cmd_adr[`SRAM_CTL_WROP_LSB +: 2]);

  // array port drives
  assign rd_type = sram_ctl_pkg::rd_port_t'(cmd_adr[`SRAM_CTL_RDTYPE_LSB +: 2]);
  // r0 is used by r0, lo and hi reads; r1 by r1, lo and hi reads
  assign r0_enb  = ra0_cmd_val & ~special & ~cmd_we & (rd_type != sram_ctl_pkg::RD_PORT_R1);
  assign r1_enb  = ra0_cmd_val & ~special & ~cmd_we & (rd_type != sram_ctl_pkg::RD_PORT_R0);
  assign r0_adr  = cmd_adr[`SRAM_CTL_ROW_LSB +: `SRAM_CTL_AW];
  assign r1_adr  = cmd_adr[`SRAM_CTL_R1_ROW_LSB +: `SRAM_CTL_AW];
  // a write with no select bit is dropped
  assign w0_enb  = ra0_cmd_val & ~special & cmd_we & (|cmd_sel);
  assign w0_adr  = cmd_adr[`SRAM_CTL_ROW_LSB +: `SRAM_CTL_AW];
  assign w0_dat  = cmd_dat;

  // bist and array config pass-through
  assign bist_ctl = (adr_bist & cmd_we) ? cmd_dat : '0;
  assign cfg_wr   = adr_arrcfg & cmd_we;
  assign cfg_wdat = cmd_dat;

  // read request, control space only decodes cfg0
  assign rd_req = ~cmd_we & (adr_cfg0 | ra0_cmd_val);

  always_comb begin
    rd_target = sram_ctl_pkg::RD_CTL;
    if (ra0_cmd_val) begin
      if (adr_bist) begin
        rd_target = sram_ctl_pkg::RD_BIST;
      end else if (adr_arrcfg) begin
        rd_target = sram_ctl_pkg::RD_CFG;
      end else begin
        case (rd_type)
          sram_ctl_pkg::RD_PORT_R0: rd_target = sram_ctl_pkg::RD_R0;
          sram_ctl_pkg::RD_PORT_R1: rd_target = sram_ctl_pkg::RD_R1;
          sram_ctl_pkg::RD_PORT_LO: rd_target = sram_ctl_pkg::RD_LO;
          default:                  rd_target = sram_ctl_pkg::RD_HI;
        endcase
      end
    end
  end

endmodule

// ==== source/read_sequencer.sv ====
// ------------------------------
// read sequencer
// waits cfg0 wait count cycles,
// then acks and muxes read data
// ------------------------------

`timescale 1ns/1ps

`include "sram_ctl_consts.svh"

module read_sequencer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          rd_req,
  input  sram_ctl_pkg::seq_state_t      rd_target,
  input  logic [`SRAM_CTL_DW-1:0]       cfg0,
  input  logic [`SRAM_CTL_DW-1:0]       r0_dat,
  input  logic [`SRAM_CTL_DW-1:0]       r1_dat,
  input  logic [`SRAM_CTL_DW-1:0]       bist_status,
  input  logic [`SRAM_CTL_DW-1:0]       cfg_rdat,
  output logic                          rd_ack,
  output logic [`SRAM_CTL_DW-1:0]       rd_dat
);

  localparam int HW = `SRAM_CTL_DW / 2;

  sram_ctl_pkg::seq_state_t     state_q;
  logic [`SRAM_CTL_WAIT_W-1:0]  wait_q;
  logic                         wait_done;

  assign wait_done = (wait_q == '0);

  // state and wait counter
  // the counter is loaded from cfg0 in the request cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= sram_ctl_pkg::IDLE;
      wait_q  <= '0;
    end else begin
      case (state_q)
        sram_ctl_pkg::IDLE: begin
          // requests outside idle are dropped
          if (rd_req) begin
            state_q <= rd_target;
            wait_q  <= cfg0[`SRAM_CTL_WAIT_W-1:0];
          end
        end
        default: begin
          if (wait_done) begin
            state_q <= sram_ctl_pkg::IDLE;
          end else begin
            wait_q <= wait_q - 1'b1;
          end
        end
      endcase
    end
  end

  // ack in the last cycle of a read state
  // with wait count W this is W+1 cycles after the command
  assign rd_ack = (state_q != sram_ctl_pkg::IDLE) & wait_done;

  // read data select by state
  always_comb begin
    case (state_q)
      sram_ctl_pkg::RD_R0:   rd_dat = r0_dat;
      sram_ctl_pkg::RD_R1:   rd_dat = r1_dat;
      // r1 half in the upper word, r0 half in the lower
      sram_ctl_pkg::RD_LO:   rd_dat = {r1_dat[HW-1:0], r0_dat[HW-1:0]};
      sram_ctl_pkg::RD_HI:   rd_dat = {r1_dat[`SRAM_CTL_DW-1:HW], r0_dat[`SRAM_CTL_DW-1:HW]};
      sram_ctl_pkg::RD_CTL:  rd_dat = cfg0;
      sram_ctl_pkg::RD_BIST: rd_dat = bist_status;
      sram_ctl_pkg::RD_CFG:  rd_dat = cfg_rdat;
      // idle reads back as all ones
      default:               rd_dat = '1;
    endcase
  end

  // ack is a single-cycle pulse
  a_ack_one_cycle : assert property (
    @(posedge clk) disable iff (rst)
    rd_ack |=> !rd_ack
  ) else $error("rd_ack held longer than one cycle");

  // every ack ends the read
  a_idle_after_ack : assert property (
    @(posedge clk) disable iff (rst)
    rd_ack |=> (state_q == sram_ctl_pkg::IDLE)
  ) else $error("sequencer not idle after rd_ack");

  // host must wait for the ack before the next read
  a_no_req_busy : assert property (
    @(posedge clk) disable iff (rst)
    rd_req |-> (state_q == sram_ctl_pkg::IDLE)
  ) else $error("read request while sequencer busy");

endmodule

// ==== source/sram_ctl_consts.svh ====
// ------------------------------
// sram controller constants
// widths, command address fields,
// decode offsets and cfg0 reset value
// ------------------------------

`ifndef SRAM_CTL_CONSTS_SVH
`define SRAM_CTL_CONSTS_SVH

// data and command address width
`define SRAM_CTL_DW 32

// row address width, 32 rows per port
`define SRAM_CTL_AW 5

// r0 and w0 row sits in address bits 6:2
`define SRAM_CTL_ROW_LSB 2
// r1 row sits in address bits 12:8
`define SRAM_CTL_R1_ROW_LSB 8
// array read type in address bits 15:14
`define SRAM_CTL_RDTYPE_LSB 14
// cfg0 write op in address bits 3:2
`define SRAM_CTL_WROP_LSB 2

// space select bits of the command address
`define SRAM_CTL_SPACE_MASK 32'h000F_0000
`define SRAM_CTL_CFG0_OFFSET 32'h0000_0000
`define SRAM_CTL_BIST_OFFSET 32'h0001_0000
`define SRAM_CTL_ARRCFG_OFFSET 32'h0002_0000

// wait count of 1, status bits low
`define SRAM_CTL_CFG0_INIT 32'h0000_0001

// read wait count field is cfg0 bits 2:0
`define SRAM_CTL_WAIT_W 3
// run mode, error and user bits start here
`define SRAM_CTL_STATUS_LSB 28

`endif

// ==== source/sram_ctl_pkg.sv ====
// ------------------------------
// sram controller types
// sequencer states, cfg0 write ops
// and array read kinds
// ------------------------------

package sram_ctl_pkg;

  // read sequencer states
  // one state per read kind, idle between reads
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    RD_CTL  = 3'd1,
    RD_BIST = 3'd2,
    RD_CFG  = 3'd3,
    RD_R0   = 3'd4,
    RD_R1   = 3'd5,
    RD_LO   = 3'd6,
    RD_HI   = 3'd7
  } seq_state_t;

  // cfg0 update ops, from command address bits 3:2
  typedef enum logic [1:0] {
    WR_LOAD   = 2'b00,
    WR_SET    = 2'b01,
    WR_CLEAR  = 2'b10,
    WR_TOGGLE = 2'b11
  } wr_op_t;

  // array read type, from command address bits 15:14
  typedef enum logic [1:0] {
    RD_PORT_R0 = 2'b00,
    RD_PORT_R1 = 2'b01,
    RD_PORT_LO = 2'b10,
    RD_PORT_HI = 2'b11
  } rd_port_t;

endpackage

// ==== source/sram_ctl_top.sv ====
// ------------------------------
// sram macro command controller
// decode, cfg0 register and read
// sequencer for a 2r1w test array
// ------------------------------

`timescale 1ns/1ps

`include "sram_ctl_consts.svh"

module sram_ctl_top (
  input  logic                      clk,
  input  logic                      rst,
  // host command
  input  logic                      ctl_cmd_val,
  input  logic                      ra0_cmd_val,
  input  logic [`SRAM_CTL_DW-1:0]   cmd_adr,
  input  logic                      cmd_we,
  input  logic [3:0]                cmd_sel,
  input  logic [`SRAM_CTL_DW-1:0]   cmd_dat,
  output logic                      rd_ack,
  output logic [`SRAM_CTL_DW-1:0]   rd_dat,
  // array ports
  output logic                      r0_enb,
  output logic [`SRAM_CTL_AW-1:0]   r0_adr,
  input  logic [`SRAM_CTL_DW-1:0]   r0_dat,
  output logic                      r1_enb,
  output logic [`SRAM_CTL_AW-1:0]   r1_adr,
  input  logic [`SRAM_CTL_DW-1:0]   r1_dat,
  output logic                      w0_enb,
  output logic [`SRAM_CTL_AW-1:0]   w0_adr,
  output logic [`SRAM_CTL_DW-1:0]   w0_dat,
  // bist and array config
  output logic [`SRAM_CTL_DW-1:0]   bist_ctl,
  input  logic [`SRAM_CTL_DW-1:0]   bist_status,
  output logic                      cfg_wr,
  output logic [`SRAM_CTL_DW-1:0]   cfg_wdat,
  input  logic [`SRAM_CTL_DW-1:0]   cfg_rdat,
  // status from cfg0
  output logic                      run_mode,
  output logic                      error,
  output logic [1:0]                user_out
);

  logic                       cfg_we;
  sram_ctl_pkg::wr_op_t       cfg_op;
  logic [`SRAM_CTL_DW-1:0]    cfg0;
  logic                       rd_req;
  sram_ctl_pkg::seq_state_t   rd_target;

  // combinational command split
  cmd_decode u_cmd_decode (
    .ctl_cmd_val (ctl_cmd_val),
    .ra0_cmd_val (ra0_cmd_val),
    .cmd_adr     (cmd_adr),
    .cmd_we      (cmd_we),
    .cmd_sel     (cmd_sel),
    .cmd_dat     (cmd_dat),
    .cfg_we      (cfg_we),
    .cfg_op      (cfg_op),
    .rd_req      (rd_req),
    .rd_target   (rd_target),
    .r0_enb      (r0_enb),
    .r0_adr      (r0_adr),
    .r1_enb      (r1_enb),
    .r1_adr      (r1_adr),
    .w0_enb      (w0_enb),
    .w0_adr      (w0_adr),
    .w0_dat      (w0_dat),
    .bist_ctl    (bist_ctl),
    .cfg_wr      (cfg_wr),
    .cfg_wdat    (cfg_wdat)
  );

  // cfg0 takes host write data directly
  cfg_reg u_cfg_reg (
    .clk      (clk),
    .rst      (rst),
    .cfg_we   (cfg_we),
    .cfg_op   (cfg_op),
    .cfg_wdat (cmd_dat),
    .cfg0     (cfg0),
    .run_mode (run_mode),
    .error    (error),
    .user_out (user_out)
  );

  read_sequencer u_read_sequencer (
    .clk         (clk),
    .rst         (rst),
    .rd_req      (rd_req),
    .rd_target   (rd_target),
    .cfg0        (cfg0),
    .r0_dat      (r0_dat),
    .r1_dat      (r1_dat),
    .bist_status (bist_status),
    .cfg_rdat    (cfg_rdat),
    .rd_ack      (rd_ack),
    .rd_dat      (rd_dat)
  );

endmodule

// ==== sram_ctl.f ====
+incdir+source
source/sram_ctl_pkg.sv
source/cfg_reg.sv
source/cmd_decode.sv
source/read_sequencer.sv
source/sram_ctl_top.sv
verif/sram_model.sv
verif/tb_sram_ctl.sv

// ==== verif/sram_model.sv ====
// ------------------------------
// behavioral 2r1w test array
// registered read ports plus bist
// and array config registers
// ------------------------------

`timescale 1ns/1ps

`include "sram_ctl_consts.svh"

module sram_model (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      r0_enb,
  input  logic [`SRAM_CTL_AW-1:0]   r0_adr,
  output logic [`SRAM_CTL_DW-1:0]   r0_dat,
  input  logic                      r1_enb,
  input  logic [`SRAM_CTL_AW-1:0]   r1_adr,
  output logic [`SRAM_CTL_DW-1:0]   r1_dat,
  input  logic                      w0_enb,
  input  logic [`SRAM_CTL_AW-1:0]   w0_adr,
  input  logic [`SRAM_CTL_DW-1:0]   w0_dat,
  input  logic [`SRAM_CTL_DW-1:0]   bist_ctl,
  output logic [`SRAM_CTL_DW-1:0]   bist_status,
  input  logic                      cfg_wr,
  input  logic [`SRAM_CTL_DW-1:0]   cfg_wdat,
  output logic [`SRAM_CTL_DW-1:0]   cfg_rdat
);

  localparam int ROWS = 1 << `SRAM_CTL_AW;

  logic [`SRAM_CTL_DW-1:0] mem [ROWS];

  // reset fills every row with a pattern built from its address
  // reads return old data on a same-row write
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ROWS; i++) begin
        mem[i] <= {8'hc3, 3'b000, i[4:0], 8'h3c, 3'b000, ~i[4:0]};
      end
      r0_dat      <= '0;
      r1_dat      <= '0;
      bist_status <= '0;
      cfg_rdat    <= '0;
    end else begin
      if (w0_enb) mem[w0_adr] <= w0_dat;
      // read data held until the next enable
      if (r0_enb) r0_dat <= mem[r0_adr];
      if (r1_enb) r1_dat <= mem[r1_adr];
      // bist engine keeps the last nonzero control word
      if (|bist_ctl) bist_status <= bist_ctl;
      if (cfg_wr) cfg_rdat <= cfg_wdat;
    end
  end

endmodule

// ==== verif/tb_sram_ctl.sv ====
// ------------------------------
// sram controller testbench
// table of commands against the
// array model, checks reads/status
// ------------------------------

`timescale 1ns/1ps

`include "sram_ctl_consts.svh"

module tb_sram_ctl;

  // entry kinds
  localparam int K_WR  = 0;  // write with table data
  localparam int K_WRR = 1;  // write with random data
  localparam int K_RD  = 2;  // read with table expected value
  localparam int K_RDA = 3;  // array read expected from shadow rows
  localparam int K_ST  = 4;  // status outputs against exp[3:0]
  localparam logic CTL = 1'b0;
  localparam logic ARR = 1'b1;
  localparam int MAXN = 40;
  localparam int TMO  = 32;

  logic clk, rst, ctl_cmd_val, ra0_cmd_val, cmd_we, rd_ack;
  logic r0_enb, r1_enb, w0_enb, cfg_wr, run_mode, error;
  logic [3:0] cmd_sel;
  logic [1:0] user_out;
  logic [`SRAM_CTL_AW-1:0] r0_adr, r1_adr, w0_adr;
  logic [`SRAM_CTL_DW-1:0] cmd_adr, cmd_dat, rd_dat, r0_dat, r1_dat, w0_dat;
  logic [`SRAM_CTL_DW-1:0] bist_ctl, bist_status, cfg_wdat, cfg_rdat;

  // stimulus table
  int t_kind [MAXN];
  logic t_space [MAXN];
  logic [31:0] t_adr [MAXN], t_dat [MAXN], t_exp [MAXN];
  logic [3:0] t_sel [MAXN];
  int n_ent = 0;

  // shadow state built from the written commands
  logic [31:0] shadow [32];
  logic [31:0] cfg_shadow;
  integer seed;
  int errors = 0;
  int checks = 0;
  bit test_ok;
  bit timed_out = 1'b0;

  sram_ctl_top u_sram_ctl_top (.*);
  sram_model u_sram_model (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic add_entry(input int kind, input logic space, input logic [31:0] adr,
                           input logic [31:0] dat, input logic [3:0] sel,
                           input logic [31:0] exp);
    t_kind[n_ent]  = kind;
    t_space[n_ent] = space;
    t_adr[n_ent]   = adr;
    t_dat[n_ent]   = dat;
    t_sel[n_ent]   = sel;
    t_exp[n_ent]   = exp;
    n_ent++;
  endtask

  // cfg0 update rule with the op from address bits 3:2
  function automatic logic [31:0] apply_op(logic [31:0] cur, logic [1:0] op, logic [31:0] d);
    case (op)
      2'b00:   return d;
      2'b01:   return cur | d;
      2'b10:   return cur & ~d;
      default: return cur ^ d;
    endcase
  endfunction

  // r0 row in bits 6:2, r1 row in bits 12:8, read type in 15:14
  function automatic logic [31:0] array_expect(logic [31:0] adr);
    logic [31:0] a;
    logic [31:0] b;
    a = shadow[adr[6:2]];
    b = shadow[adr[12:8]];
    case (adr[15:14])
      2'b00:   return a;
      2'b01:   return b;
      2'b10:   return {b[15:0], a[15:0]};
      default: return {b[31:16], a[31:16]};
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic clear_cmd();
    ctl_cmd_val = 1'b0;
    ra0_cmd_val = 1'b0;
    cmd_we      = 1'b0;
    cmd_adr     = '0;
    cmd_dat     = '0;
    cmd_sel     = '0;
  endtask

  task automatic send_cmd(input logic space, input logic we, input logic [31:0] adr,
                          input logic [31:0] dat, input logic [3:0] sel);
    @(negedge clk);
    ctl_cmd_val = ~space;
    ra0_cmd_val = space;
    cmd_we      = we;
    cmd_adr     = adr;
    cmd_dat     = dat;
    cmd_sel     = sel;
  endtask

  // ack due W+1 cycles after the command with W from the current cfg0
  task automatic do_read(input logic space, input logic [31:0] adr, input logic [31:0] exp);
    int cyc;
    int want;
    want = int'(cfg_shadow[2:0]) + 1;
    send_cmd(space, 1'b0, adr, 32'h0, 4'h0);
    cyc = 0;
    do begin
      @(negedge clk);
      clear_cmd();
      cyc++;
    end while (!rd_ack && cyc < TMO);
    if (!rd_ack) begin
      $display("timeout: no rd_ack within %0d cycles of the read command", TMO);
      errors++;
      test_ok = 1'b0;
      timed_out = 1'b1;
    end else begin
      check("rd_ack latency", cyc, want);
      check("rd_dat", rd_dat, exp);
      @(negedge clk);
      check("rd_ack second cycle", {31'h0, rd_ack}, 32'h0);
    end
  endtask

  task automatic build_table();
    add_entry(K_RD,  CTL, 32'h0000_0000, 32'h0, 4'hf, `SRAM_CTL_CFG0_INIT);
    add_entry(K_ST,  CTL, 32'h0000_0000, 32'h0, 4'hf, 32'h0);
    // load, set, clear, toggle, each read back; W goes 3, 3, 3, 7
    add_entry(K_WR,  CTL, 32'h0000_0000, 32'h1234_5673, 4'hf, 32'h0);
    add_entry(K_RD,  CTL, 32'h0000_0000, 32'h0, 4'hf, 32'h1234_5673);
    add_entry(K_WR,  CTL, 32'h0000_0004, 32'h0000_0f00, 4'hf, 32'h0);
    add_entry(K_RD,  CTL, 32'h0000_0000, 32'h0, 4'hf, 32'h1234_5f73);
    add_entry(K_WR,  CTL, 32'h0000_0008, 32'h0204_0070, 4'hf, 32'h0);
    add_entry(K_RD,  CTL, 32'h0000_0000, 32'h0, 4'hf, 32'h1030_5f03);
    add_entry(K_WR,  CTL, 32'h0000_000c, 32'h0f0f_0004, 4'hf, 32'h0);
    add_entry(K_RD,  CTL, 32'h0000_0000, 32'h0, 4'hf, 32'h1f3f_5f07);
    add_entry(K_ST,  CTL, 32'h0000_0000, 32'h0, 4'hf, 32'h1);
    // all four status bits set
    add_entry(K_WR,  CTL, 32'h0000_0004, 32'hf000_0000, 4'hf, 32'h0);
    add_entry(K_ST,  CTL, 32'h0000_0000, 32'h0, 4'hf, 32'hf);
    add_entry(K_RD,  CTL, 32'h0000_0000, 32'h0, 4'hf, 32'hff3f_5f07);
    // wait count 0
    add_entry(K_WR,  CTL, 32'h0000_0000, 32'h0000_0000, 4'hf, 32'h0);
    add_entry(K_RD,  CTL, 32'h0000_0000, 32'h0, 4'hf, 32'h0);
    add_entry(K_WR,  CTL, 32'h0000_0000, 32'h0000_0002, 4'hf, 32'h0);
    // random rows 3, 7, 12, 21 then each read kind
    add_entry(K_WRR, ARR, 32'h0000_000c, 32'h0, 4'hf, 32'h0);
    add_entry(K_WRR, ARR, 32'h0000_001c, 32'h0, 4'hf, 32'h0);
    add_entry(K_WRR, ARR, 32'h0000_0030, 32'h0, 4'h3, 32'h0);
    add_entry(K_WRR, ARR, 32'h0000_0054, 32'h0, 4'h8, 32'h0);
    add_entry(K_RDA, ARR, 32'h0000_000c, 32'h0, 4'h0, 32'h0);
    add_entry(K_RDA, ARR, 32'h0000_4700, 32'h0, 4'h0, 32'h0);
    add_entry(K_RDA, ARR, 32'h0000_8c54, 32'h0, 4'h0, 32'h0);
    add_entry(K_RDA, ARR, 32'h0000_c31c, 32'h0, 4'h0, 32'h0);
    // no select bit so row 12 keeps its data
    add_entry(K_WR,  ARR, 32'h0000_0030, 32'hdead_beef, 4'h0, 32'h0);
    add_entry(K_RDA, ARR, 32'h0000_0030, 32'h0, 4'h0, 32'h0);
    add_entry(K_WR,  CTL, 32'h0000_0000, 32'h0000_0003, 4'hf, 32'h0);
    add_entry(K_RDA, ARR, 32'h0000_5500, 32'h0, 4'h0, 32'h0);
    // bist and array config aliasing row 2
    add_entry(K_WRR, ARR, 32'h0000_0008, 32'h0, 4'hf, 32'h0);
    add_entry(K_WR,  ARR, `SRAM_CTL_BIST_OFFSET | 32'h8, 32'h0bad_f00d, 4'hf, 32'h0);
    add_entry(K_WR,  ARR, `SRAM_CTL_ARRCFG_OFFSET | 32'h8, 32'h5eed_1234, 4'hf, 32'h0);
    add_entry(K_RD,  ARR, `SRAM_CTL_BIST_OFFSET, 32'h0, 4'h0, 32'h0bad_f00d);
    add_entry(K_RD,  ARR, `SRAM_CTL_ARRCFG_OFFSET, 32'h0, 4'h0, 32'h5eed_1234);
    add_entry(K_RDA, ARR, 32'h0000_0008, 32'h0, 4'h0, 32'h0);
  endtask

  initial begin
    logic [31:0] d;
    logic [31:0] space;
    seed = 32'h8f51_37fb;
    cfg_shadow = `SRAM_CTL_CFG0_INIT;
    rst = 1'b1;
    clear_cmd();
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_ent && !timed_out; i++) begin
      test_ok = 1'b1;
      case (t_kind[i])
        K_WR, K_WRR: begin
          d = (t_kind[i] == K_WRR) ? $random(seed) : t_dat[i];
          send_cmd(t_space[i], 1'b1, t_adr[i], d, t_sel[i]);
          @(negedge clk);
          clear_cmd();
          space = t_adr[i] & `SRAM_CTL_SPACE_MASK;
          // array row written only with a select bit and outside bist/config
          if (t_space[i] == CTL) begin
            cfg_shadow = apply_op(cfg_shadow, t_adr[i][3:2], d);
          end else if (|t_sel[i] && space != `SRAM_CTL_BIST_OFFSET &&
                       space != `SRAM_CTL_ARRCFG_OFFSET) begin
            shadow[t_adr[i][6:2]] = d;
          end
        end
        K_RD:  do_read(t_space[i], t_adr[i], t_exp[i]);
        K_RDA: do_read(t_space[i], t_adr[i], array_expect(t_adr[i]));
        default: begin
          @(negedge clk);
          check("status {run_mode,error,user_out}", {28'h0, run_mode, error, user_out},
                t_exp[i]);
        end
      endcase
      $display("test %0d kind %0d adr %h %s", i, t_kind[i], t_adr[i], test_ok ? "ok" : "FAILED");
    end
    $display("tests %0d checks %0d errors %0d", n_ent, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
